/* rtl/arb_pkg.sv */
package arb_pkg;

  // the request word is split into num_pri groups of num_reqs requestors
  // bit p*num_reqs+r of the word belongs to requestor r at priority p
  localparam int num_reqs = 4;

  // the last stage chooses among this many priorities
  localparam int num_pri = 4;

  // index widths follow from the group sizes above
  localparam int req_w = 2;
  localparam int pri_w = 2;

  // one weight per input, compared against an 8-bit random draw
  localparam int weight_w = 8;

  // requestor index inside one priority group
  typedef logic [req_w-1:0] req_idx_t;

  // priority index chosen by the last stage
  typedef logic [pri_w-1:0] pri_idx_t;

  // weight of one arbiter input
  // a weight of 255 is always eligible, a weight of 0 never is
  // unless nothing else requests
  typedef logic [weight_w-1:0] weight_t;

endpackage

/* rtl/arb_lfsr.sv */
`timescale 1ns/1ps

module arb_lfsr #(
  parameter arb_pkg::weight_t seed = 8'h01
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             step,
  output arb_pkg::weight_t value
);
  import arb_pkg::*;

  // current LFSR state, which never reaches zero
  weight_t state;
  weight_t next_state;
  weight_t start;

  // an all-zero state would lock the register, so a zero seed becomes one
  assign start = (seed == '0) ? weight_t'(1) : seed;

  // right-shifting Galois form of x^8 + x^6 + x^5 + x^4 + 1
  // the feedback mask b8 gives the full 255-state cycle
  always_comb begin
    next_state = {1'b0, state[weight_w-1:1]};
    if (state[0]) begin
      next_state = next_state ^ 8'hb8;
    end
  end

  // the register only moves when the owner asks for a new draw
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= start;
    end else if (step) begin
      state <= next_state;
    end
  end

  // states run 1..255, so subtracting one gives r in 0..254
  assign value = state - weight_t'(1);

endmodule

/* rtl/wrand_arb.sv */
`timescale 1ns/1ps

module wrand_arb #(
  parameter int               n_in = 4,
  parameter arb_pkg::weight_t seed = 8'h01
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               advance,
  input  logic             [n_in-1:0]        req,
  input  arb_pkg::weight_t [n_in-1:0]        weight,
  output logic                               win_v,
  output logic             [$clog2(n_in)-1:0] win
);
  import arb_pkg::*;

  // random draw r for the current arbitration round
  weight_t rnd;

  // inputs whose weight beats the draw
  logic [n_in-1:0] above;

  // set actually searched by the round-robin pick
  logic [n_in-1:0] elig;

  // last winner, the search starts one place after it
  logic [$clog2(n_in)-1:0] ptr;

  // the draw only changes when a winner is actually consumed
  arb_lfsr #(
    .seed (seed)
  ) lfsr_i (
    .clk   (clk),
    .rst   (rst),
    .step  (advance && win_v),
    .value (rnd)
  );

  // an input is a candidate when it requests and its weight is above r
  always_comb begin
    for (int i = 0; i < n_in; i++) begin
      above[i] = req[i] && (weight[i] > rnd);
    end
  end

  // fall back to every requesting input when no weight beat the draw
  assign elig = (|above) ? above : req;

  // there is a winner whenever anything requests at all
  assign win_v = |elig;

  // round-robin search starting just after the pointer and wrapping around
  // the first hit stops the search, so later candidates are ignored
  always_comb begin : pick
    int   idx;
    logic found;
    found = 1'b0;
    idx = 0;
    win = '0;
    for (int k = 1; k <= n_in; k++) begin
      idx = (int'(ptr) + k) % n_in;
      if (!found && elig[idx]) begin
        found = 1'b1;
        win = idx[$clog2(n_in)-1:0];
      end
    end
  end

  // reset parks the pointer on the last input so the first search begins at 0
  // the pointer only follows a winner that was actually taken
  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= ($clog2(n_in))'(n_in - 1);
    end else if (advance && win_v) begin
      ptr <= win;
    end
  end

endmodule

/* rtl/grant_if.sv */
`timescale 1ns/1ps

interface grant_if;
  import arb_pkg::*;

  // a winner exists for the current requests
  logic valid;

  // winning priority and its winning requestor
  pri_idx_t pri;
  req_idx_t req;

  // one-cycle pulse from the port when it captures the winner
  // the arbiter state moves on the same clock edge
  logic take;

  // the arbiter side offers the winner and watches for take
  modport arb (
    output valid,
    output pri,
    output req,
    input  take
  );

  // the port side consumes the winner and raises take
  modport port (
    input  valid,
    input  pri,
    input  req,
    output take
  );

endinterface

/* rtl/two_stage_arb.sv */
`timescale 1ns/1ps

module two_stage_arb (
  input  logic                                                     clk,
  input  logic                                                     rst,
  input  logic             [arb_pkg::num_pri*arb_pkg::num_reqs-1:0] reqs,
  input  arb_pkg::weight_t [arb_pkg::num_pri*arb_pkg::num_reqs-1:0] weight_req,
  input  arb_pkg::weight_t [arb_pkg::num_pri-1:0]                  weight_pri,
  grant_if.arb                                                     g
);
  import arb_pkg::*;

  // one valid bit and one winner index per priority from the first stage
  logic     [num_pri-1:0] frst_v;
  req_idx_t [num_pri-1:0] frst_win;

  // result of the last stage across priorities
  logic     last_v;
  pri_idx_t last_win;

  // first stage, one arbiter per priority over that priority's requestors
  // each gets its own seed so the groups do not draw in lockstep
  for (genvar p = 0; p < num_pri; p++) begin : frst
    // only the priority that actually won moves its pointer and LFSR
    logic adv;

    assign adv = g.take && (last_win == pri_idx_t'(p));

    wrand_arb #(
      .n_in (num_reqs),
      .seed (weight_t'(17 + 40 * p))
    ) arb_i (
      .clk     (clk),
      .rst     (rst),
      .advance (adv),
      .req     (reqs[p*num_reqs +: num_reqs]),
      .weight  (weight_req[p*num_reqs +: num_reqs]),
      .win_v   (frst_v[p]),
      .win     (frst_win[p])
    );
  end

  // last stage picks a priority among those with a first-stage winner
  wrand_arb #(
    .n_in (num_pri),
    .seed (8'ha5)
  ) last_i (
    .clk     (clk),
    .rst     (rst),
    .advance (g.take),
    .req     (frst_v),
    .weight  (weight_pri),
    .win_v   (last_v),
    .win     (last_win)
  );

  // the requestor comes from the first stage of the winning priority
  assign g.valid = last_v;
  assign g.pri = last_win;
  assign g.req = frst_win[last_win];

endmodule

/* rtl/grant_port.sv */
`timescale 1ns/1ps

module grant_port (
  input  logic              clk,
  input  logic              rst,
  input  logic              grant_ack,
  grant_if.port             g,
  output logic              grant_req,
  output arb_pkg::pri_idx_t grant_pri,
  output arb_pkg::req_idx_t grant_who
);

  // idle waits for a winner, assert holds grant_req high,
  // release waits for the consumer to drop ack
  enum logic [1:0] {st_idle, st_assert, st_release} state;

  logic take;

  // capture only when idle and the previous handshake is fully closed
  assign take = (state == st_idle) && g.valid && !grant_ack;
  assign g.take = take;

  // handshake sequencing, one step per sampled edge of ack
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (take) begin
            state <= st_assert;
          end
        end
        st_assert: begin
          // req drops the cycle after ack is seen high
          if (grant_ack) begin
            state <= st_release;
          end
        end
        st_release: begin
          // back to idle once the consumer has let go of ack
          if (!grant_ack) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // the captured winner stays put for the whole handshake
  always_ff @(posedge clk) begin
    if (take) begin
      grant_pri <= g.pri;
      grant_who <= g.req;
    end
  end

  // req comes straight from the state register, one cycle after capture
  assign grant_req = (state == st_assert);

endmodule

/* rtl/sched_arb_top.sv */
`timescale 1ns/1ps

module sched_arb_top (
  input  logic                                                     clk,
  input  logic                                                     rst,
  input  logic             [arb_pkg::num_pri*arb_pkg::num_reqs-1:0] reqs,
  input  arb_pkg::weight_t [arb_pkg::num_pri*arb_pkg::num_reqs-1:0] weight_req,
  input  arb_pkg::weight_t [arb_pkg::num_pri-1:0]                  weight_pri,
  output logic                                                     grant_req,
  output arb_pkg::pri_idx_t                                        grant_pri,
  output arb_pkg::req_idx_t                                        grant_who,
  input  logic                                                     grant_ack
);

  // current winner travels from the arbiter to the handshake port here
  grant_if g_if ();

  // two-level weighted-random selection over the request word
  two_stage_arb two_stage_arb_i (
    .clk        (clk),
    .rst        (rst),
    .reqs       (reqs),
    .weight_req (weight_req),
    .weight_pri (weight_pri),
    .g          (g_if.arb)
  );

  // four-phase req/ack presentation of each taken winner
  // its take pulse is what advances the arbiter state
  grant_port grant_port_i (
    .clk       (clk),
    .rst       (rst),
    .grant_ack (grant_ack),
    .g         (g_if.port),
    .grant_req (grant_req),
    .grant_pri (grant_pri),
    .grant_who (grant_who)
  );

endmodule

/* bench/sched_arb_assert.sv */
`timescale 1ns/1ps

module sched_arb_assert (
  input logic              clk,
  input logic              rst,
  input logic              grant_req,
  input logic              grant_ack,
  input arb_pkg::pri_idx_t grant_pri,
  input arb_pkg::req_idx_t grant_who
);

  // a new grant may only start once the previous ack has gone low
  rise_with_ack_low: assert property (@(posedge clk) disable iff (rst)
    $rose(grant_req) |-> !$past(grant_ack))
    else $error("grant_req rose while grant_ack was still high");

  // the captured winner must not move while the consumer may be reading it
  hold_while_req: assert property (@(posedge clk) disable iff (rst)
    (grant_req && $past(grant_req)) |-> ($stable(grant_pri) && $stable(grant_who)))
    else $error("grant_pri or grant_who changed while grant_req was high");

  // req only drops in answer to an ack seen on the previous edge
  fall_after_ack: assert property (@(posedge clk) disable iff (rst)
    $fell(grant_req) |-> $past(grant_ack))
    else $error("grant_req fell without a preceding grant_ack");

endmodule

// every grant port in the design gets the handshake checks
bind grant_port sched_arb_assert grant_port_assert_i (
  .clk       (clk),
  .rst       (rst),
  .grant_req (grant_req),
  .grant_ack (grant_ack),
  .grant_pri (grant_pri),
  .grant_who (grant_who)
);

/* bench/tb_sched_arb.sv */
`timescale 1ns/1ps

module tb_sched_arb;
  import arb_pkg::*;

  // test lengths in cycles, the watchdog limit is built from them
  localparam int reset_cycles = 16;
  localparam int idle_cycles = 20;
  localparam int hold_cycles = 8;
  localparam int n_random = 40;
  // one handshake takes about six cycles, eight leaves slack
  localparam int hs_cycles = 8;
  localparam int n_grants = 6 + 5 + 16 + n_random + 2;
  localparam int test_cycles = reset_cycles + idle_cycles + hold_cycles + n_grants * hs_cycles;
  localparam int watchdog_ns = 2 * 10 * test_cycles;
  localparam int wait_limit = 50;

  logic                           clk;
  logic                           rst;
  logic [num_pri*num_reqs-1:0]    reqs;
  weight_t [num_pri*num_reqs-1:0] weight_req;
  weight_t [num_pri-1:0]          weight_pri;
  logic                           grant_req;
  pri_idx_t                       grant_pri;
  req_idx_t                       grant_who;
  logic                           grant_ack;

  int errors;
  int checks;
  int tests;

  // reference round-robin pointers, last stage and one per priority
  int pri_ptr;
  int req_ptr [num_pri];

  sched_arb_top sched_arb_top_i (
    .clk        (clk),
    .rst        (rst),
    .reqs       (reqs),
    .weight_req (weight_req),
    .weight_pri (weight_pri),
    .grant_req  (grant_req),
    .grant_pri  (grant_pri),
    .grant_who  (grant_who),
    .grant_ack  (grant_ack)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // nothing can hang longer than twice the planned run
  initial begin
    #(watchdog_ns);
    $display("watchdog expired after %0d ns, the tests did not finish", watchdog_ns);
    $display("Result: FAILED");
    $finish;
  end

  task automatic check_pri(input string name, input pri_idx_t got, input pri_idx_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_who(input string name, input req_idx_t got, input req_idx_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // first set bit strictly after ptr, wrapping around, or -1 for an empty mask
  // scanning from the far end down lets the nearest hit overwrite the others
  function automatic int rr_next(input logic [num_reqs-1:0] mask, input int ptr);
    int idx;
    rr_next = -1;
    for (int k = num_reqs; k >= 1; k--) begin
      idx = (ptr + k) % num_reqs;
      if (mask[idx]) begin
        rr_next = idx;
      end
    end
  endfunction

  // with equal weights in a group the eligible set is just the requesting set
  task automatic expect_grant(input logic [15:0] pattern, output pri_idx_t ep,
                              output req_idx_t ew);
    logic [num_pri-1:0] busy;
    int p;
    int w;
    for (int i = 0; i < num_pri; i++) begin
      busy[i] = |pattern[i*num_reqs +: num_reqs];
    end
    p = rr_next(busy, pri_ptr);
    w = rr_next(pattern[p*num_reqs +: num_reqs], req_ptr[p]);
    ep = pri_idx_t'(p);
    ew = req_idx_t'(w);
  endtask

  // polls at the falling edge so the registered outputs are settled
  task automatic wait_grant();
    int n;
    n = 0;
    @(negedge clk);
    while (!grant_req && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (!grant_req) begin
      errors++;
      $display("ERROR at %0t: grant_req did not rise within %0d cycles", $time, wait_limit);
    end
  endtask

  // consumer side of phases two to four
  task automatic release_grant();
    int n;
    n = 0;
    @(posedge clk);
    grant_ack <= 1'b1;
    @(negedge clk);
    while (grant_req && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (grant_req) begin
      errors++;
      $display("ERROR at %0t: grant_req stayed high after grant_ack was raised", $time);
    end
    @(posedge clk);
    grant_ack <= 1'b0;
  endtask

  // one full handshake on a pattern whose winner is already known
  task automatic serve(input logic [15:0] pattern, input pri_idx_t ep, input req_idx_t ew);
    @(posedge clk);
    reqs <= pattern;
    wait_grant();
    check_pri("grant_pri", grant_pri, ep);
    check_who("grant_who", grant_who, ew);
    check_bit("reqs[granted]", pattern[int'(grant_pri) * num_reqs + int'(grant_who)], 1'b1);
    release_grant();
    // the DUT pointers follow the winner it captured
    pri_ptr = int'(ep);
    req_ptr[ep] = int'(ew);
  endtask

  task automatic serve_model(input logic [15:0] pattern);
    pri_idx_t ep;
    req_idx_t ew;
    expect_grant(pattern, ep, ew);
    serve(pattern, ep, ew);
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests++;
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic test_reset_idle();
    int e;
    e = errors;
    repeat (reset_cycles) begin
      @(negedge clk);
      check_bit("grant_req", grant_req, 1'b0);
    end
    @(posedge clk);
    rst <= 1'b0;
    repeat (idle_cycles) begin
      @(negedge clk);
      check_bit("grant_req", grant_req, 1'b0);
    end
    report_test("reset_idle", e);
  endtask

  task automatic test_single();
    int e;
    int bits [3] = '{5, 14, 0};
    logic [15:0] one_hot;
    e = errors;
    foreach (bits[i]) begin
      one_hot = '0;
      one_hot[bits[i]] = 1'b1;
      repeat (2) begin
        serve(one_hot, pri_idx_t'(bits[i] / num_reqs), req_idx_t'(bits[i] % num_reqs));
      end
    end
    report_test("single_request", e);
  endtask

  // priority 2 has not won yet, so its pointer still parks on requestor 3
  task automatic test_round_robin();
    int e;
    e = errors;
    for (int k = 0; k < 5; k++) begin
      serve(16'h0f00, pri_idx_t'(2), req_idx_t'(k % num_reqs));
    end
    report_test("round_robin", e);
  endtask

  // weight 255 beats every draw and weight 0 none, so the result is forced
  task automatic test_weight_exclusion();
    int e;
    e = errors;
    // requests go quiet in the same edge so no capture sees half the setup
    @(posedge clk);
    reqs <= '0;
    weight_pri[0] <= 8'h00;
    weight_pri[3] <= 8'hff;
    repeat (8) begin
      serve(16'h1001, pri_idx_t'(3), req_idx_t'(0));
    end
    @(posedge clk);
    reqs <= '0;
    weight_pri <= {4{8'h80}};
    weight_req[4] <= 8'h00;
    weight_req[5] <= 8'hff;
    weight_req[6] <= 8'h00;
    weight_req[7] <= 8'h00;
    repeat (8) begin
      serve(16'h00f0, pri_idx_t'(1), req_idx_t'(1));
    end
    @(posedge clk);
    reqs <= '0;
    weight_req <= {16{8'h80}};
    report_test("weight_exclusion", e);
  endtask

  task automatic test_random();
    int e;
    logic [31:0] rnd;
    logic [15:0] pattern;
    e = errors;
    repeat (n_random) begin
      rnd = $urandom();
      pattern = rnd[15:0];
      if (pattern == '0) begin
        pattern = 16'h0001;
      end
      serve_model(pattern);
    end
    report_test("random_patterns", e);
  endtask

  // the held grant must survive request churn and leave the pointers alone
  task automatic test_backpressure();
    int e;
    pri_idx_t ep;
    req_idx_t ew;
    logic [31:0] rnd;
    e = errors;
    expect_grant(16'h3c5a, ep, ew);
    @(posedge clk);
    reqs <= 16'h3c5a;
    wait_grant();
    check_pri("grant_pri", grant_pri, ep);
    check_who("grant_who", grant_who, ew);
    pri_ptr = int'(ep);
    req_ptr[ep] = int'(ew);
    repeat (hold_cycles) begin
      @(posedge clk);
      rnd = $urandom();
      reqs <= rnd[15:0];
      @(negedge clk);
      check_bit("grant_req", grant_req, 1'b1);
      check_pri("grant_pri", grant_pri, ep);
      check_who("grant_who", grant_who, ew);
    end
    @(posedge clk);
    reqs <= 16'h8421;
    release_grant();
    serve_model(16'h8421);
    report_test("backpressure", e);
  endtask

  initial begin
    void'($urandom(32'hfee7));
    errors = 0;
    checks = 0;
    tests = 0;
    pri_ptr = num_pri - 1;
    for (int i = 0; i < num_pri; i++) begin
      req_ptr[i] = num_reqs - 1;
    end
    rst = 1'b1;
    reqs = '0;
    weight_req = {16{8'h80}};
    weight_pri = {4{8'h80}};
    grant_ack = 1'b0;
    test_reset_idle();
    test_single();
    test_round_robin();
    test_weight_exclusion();
    test_random();
    test_backpressure();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* flist.f */
rtl/arb_pkg.sv
rtl/arb_lfsr.sv
rtl/wrand_arb.sv
rtl/grant_if.sv
rtl/two_stage_arb.sv
rtl/grant_port.sv
rtl/sched_arb_top.sv
bench/sched_arb_assert.sv
bench/tb_sched_arb.sv

/* Makefile */
# Verilator build and run for the scheduler testbench

VERILATOR ?= verilator
TOP       ?= tb_sched_arb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Result: FAILED

SRCS := $(shell cat $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# an assertion stop or crash also counts as a failure
run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
